/* hw/pract_filter_settings.svh */
`ifndef PRACT_FILTER_SETTINGS_SVH
`define PRACT_FILTER_SETTINGS_SVH

// Filter length, must stay odd for the folded structure
`define FILTER_TAPS 17

// Index of the center tap
`define HALF_TAPS ((`FILTER_TAPS - 1) / 2)

// Sample width, 1s17
`define SAMPLE_W 18

// A mirrored pair needs one more bit than a sample
`define FOLD_W 19

// One quarter step of full scale in 1s17
`define LEVEL_STEP 32768

`endif

/* hw/pract_filter_pkg.sv */
`include "pract_filter_settings.svh"

package pract_filter_pkg;

	// Samples, tap products and the filter output
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// Sum of a mirrored tap pair
	typedef logic signed [`FOLD_W-1:0] fold_t;

	// Half of the symmetric impulse response in 1s17 units,
	// from tap 0 up to and including the center tap.
	// Tap FILTER_TAPS-1-k uses the same value as tap k
	localparam int coeff_table [0:`HALF_TAPS] = '{
		-150,
		-420,
		310,
		1380,
		-620,
		-3900,
		1850,
		14500,
		28000
	};

	// Sum of magnitudes with mirrored taps counted twice is 74260
	// Worst case output at 0.75 full scale stays well inside 18 bits

endpackage

/* hw/fir_sample_delay_line.sv */
`timescale 1ns/1ps

module fir_sample_delay_line #(
	parameter int TAPS = 17
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      sam_clk_en,
	input  pract_filter_pkg::sample_t x_in,
	output pract_filter_pkg::sample_t taps [0:TAPS-1]
);

	// Tap 0 holds the newest sample
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < TAPS; i++)
			begin
				taps[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			taps[0] <= x_in;
			// Everything older moves one place down the line
			for (int i = 1; i < TAPS; i++)
			begin
				taps[i] <= taps[i - 1];
			end
		end
	end

endmodule

/* hw/fir_tap_multiplier.sv */
`timescale 1ns/1ps
`include "pract_filter_settings.svh"

module fir_tap_multiplier #(
	parameter int TAP_INDEX = 0,
	parameter bit CENTER    = 1'b0
)
(
	input  pract_filter_pkg::sample_t near_sample,
	input  pract_filter_pkg::sample_t far_sample,
	output pract_filter_pkg::sample_t product
);

	// Grid of quarter steps
	localparam int STEP_SHIFT = $clog2(`LEVEL_STEP);
	localparam int LEVEL_W    = `FOLD_W - STEP_SHIFT;

	// Pair sums of symbols reach six quarter steps either way
	localparam int MAX_LEVEL = 6;
	localparam int LEVELS    = 2 * MAX_LEVEL + 1;
	localparam int INDEX_W   = $clog2(LEVELS);

	localparam int COEFF = pract_filter_pkg::coeff_table[TAP_INDEX];

	// coeff * level / 4, nearest integer with ties away from zero
	function automatic int scaled_product(input int coeff, input int level);
		int num;
		num = coeff * level;
		if (num >= 0)
			return (num + 2) / 4;
		return -((2 - num) / 4);
	endfunction

	pract_filter_pkg::fold_t   fold;
	logic                      on_grid;
	logic signed [LEVEL_W-1:0] level_q;
	logic [INDEX_W-1:0]        level_index;
	pract_filter_pkg::sample_t level_products [0:LEVELS-1];

	// Fold the mirrored pair, the center tap has no partner
	if (CENTER)
	begin : g_center
		assign fold = pract_filter_pkg::fold_t'(near_sample);
	end
	else
	begin : g_pair
		assign fold = pract_filter_pkg::fold_t'(near_sample)
			+ pract_filter_pkg::fold_t'(far_sample);
	end

	// Product for every level this tap can see
	for (genvar l = 0; l < LEVELS; l++)
	begin : g_level
		assign level_products[l] =
			pract_filter_pkg::sample_t'(scaled_product(COEFF, l - MAX_LEVEL));
	end

	// Level decode
	assign on_grid     = (fold[STEP_SHIFT-1:0] == '0);
	assign level_q     = fold[`FOLD_W-1:STEP_SHIFT];
	assign level_index = INDEX_W'(level_q + MAX_LEVEL);

	// Off the grid or beyond the table gives nothing
	always_comb
	begin
		if (on_grid && level_q >= -MAX_LEVEL && level_q <= MAX_LEVEL)
			product = level_products[level_index];
		else
			product = '0;
	end

endmodule

/* hw/fir_adder_tree.sv */
`timescale 1ns/1ps

module fir_adder_tree #(
	parameter int INPUTS = 9
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      sam_clk_en,
	input  pract_filter_pkg::sample_t products [0:INPUTS-1],
	output pract_filter_pkg::sample_t y
);

	// Each level halves the term count, rounding up
	localparam int LEVELS = $clog2(INPUTS);

	function automatic int level_width(input int level);
		return (INPUTS + (1 << level) - 1) >> level;
	endfunction

	// Level 0 holds the products, level LEVELS the full sum
	pract_filter_pkg::sample_t node [0:LEVELS][0:INPUTS-1];

	always_comb
	begin
		for (int l = 0; l <= LEVELS; l++)
		begin
			for (int n = 0; n < INPUTS; n++)
			begin
				node[l][n] = '0;
			end
		end

		for (int n = 0; n < INPUTS; n++)
		begin
			node[0][n] = products[n];
		end

		for (int l = 1; l <= LEVELS; l++)
		begin
			for (int n = 0; n < level_width(l - 1) / 2; n++)
			begin
				node[l][n] = node[l - 1][2 * n] + node[l - 1][2 * n + 1];
			end
			// Lone term rides up to the next level
			if (level_width(l - 1) % 2 == 1)
			begin
				node[l][level_width(l - 1) / 2] = node[l - 1][level_width(l - 1) - 1];
			end
		end
	end

	// Output register, one update per sample
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			y <= '0;
		else if (sam_clk_en)
			y <= node[LEVELS][0];
	end

endmodule

/* hw/pract_filter.sv */
`timescale 1ns/1ps
`include "pract_filter_settings.svh"

module pract_filter (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      sam_clk_en,
	input  pract_filter_pkg::sample_t x_in,
	output pract_filter_pkg::sample_t y
);

	// Sample history, newest first
	pract_filter_pkg::sample_t taps [0:`FILTER_TAPS-1];

	// One product per folded pair plus the center
	pract_filter_pkg::sample_t products [0:`HALF_TAPS];

	fir_sample_delay_line #(
		.TAPS(`FILTER_TAPS)
	) delay_line_i (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.x_in(x_in),
		.taps(taps)
	);

	// Tap k pairs with its mirror, the last one sees the center alone
	for (genvar k = 0; k <= `HALF_TAPS; k++)
	begin : g_tap
		fir_tap_multiplier #(
			.TAP_INDEX(k),
			.CENTER(k == `HALF_TAPS)
		) tap_multiplier_i (
			.near_sample(taps[k]),
			.far_sample(taps[`FILTER_TAPS - 1 - k]),
			.product(products[k])
		);
	end

	fir_adder_tree #(
		.INPUTS(`HALF_TAPS + 1)
	) adder_tree_i (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.products(products),
		.y(y)
	);

endmodule

/* verification/pract_filter_tests.svh */
// One of the four PAM levels in 1s17
function automatic int random_symbol();
	case ($urandom_range(0, 3))
		0: return -3 * `LEVEL_STEP;
		1: return -1 * `LEVEL_STEP;
		2: return `LEVEL_STEP;
		default: return 3 * `LEVEL_STEP;
	endcase
endfunction

// Push zeros through the whole line
task automatic flush_line(input string test_name);
	for (int i = 0; i < `FILTER_TAPS; i++)
	begin
		strobe_sample(test_name, 0);
		random_gap(test_name);
	end
endtask

task automatic idle_after_reset();
	string name;
	name = "reset_idle";
	check_value(name, 0, int'(y));
	for (int i = 0; i < 12; i++)
	begin
		strobe_sample(name, 0);
		check_value(name, 0, int'(y));
		random_gap(name);
	end
endtask

task automatic impulse_response();
	string name;
	int coeff_index;
	int impulse_y;
	name = "impulse";
	flush_line(name);
	strobe_sample(name, 3 * `LEVEL_STEP);
	random_gap(name);
	// The impulse walks from tap 0 to the end and mirrors after the center
	for (int j = 0; j < `FILTER_TAPS; j++)
	begin
		strobe_sample(name, 0);
		coeff_index = (j <= `HALF_TAPS) ? j : `FILTER_TAPS - 1 - j;
		impulse_y = quarter_product(pract_filter_pkg::coeff_table[coeff_index], 3);
		check_value(name, impulse_y, int'(y));
		random_gap(name);
	end
	strobe_sample(name, 0);
	check_value(name, 0, int'(y));
endtask

task automatic hold_without_strobe();
	string name;
	name = "hold";
	for (int i = 0; i < 6; i++)
		strobe_sample(name, random_symbol());
	idle_cycles(name, 7);
	for (int i = 0; i < 20; i++)
	begin
		strobe_sample(name, random_symbol());
		random_gap(name);
	end
endtask

task automatic pam_stream();
	string name;
	name = "random_stream";
	for (int i = 0; i < 200; i++)
	begin
		strobe_sample(name, random_symbol());
		random_gap(name);
	end
endtask

task automatic off_grid_samples();
	string name;
	int offsets [0:`FILTER_TAPS-2];
	int value;
	int level;
	name = "off_grid";
	flush_line(name);
	// Lone off-grid samples
	for (int i = 0; i < `FILTER_TAPS - 1; i++)
	begin
		value = int'($urandom_range(0, 120000)) - 60000;
		if (value % `LEVEL_STEP == 0)
			value = value + 777;
		offsets[i] = value;
		strobe_sample(name, value);
		random_gap(name);
	end
	// Partners 16 samples later put the outer pair back on the grid
	for (int i = 0; i < `FILTER_TAPS - 1; i++)
	begin
		level = int'($urandom_range(0, 2)) - 1;
		strobe_sample(name, level * `LEVEL_STEP - offsets[i]);
		random_gap(name);
	end
	flush_line(name);
	// Full-scale negative pair folds beyond the level table
	strobe_sample(name, -131072);
	for (int i = 0; i < `FILTER_TAPS - 2; i++)
		strobe_sample(name, 0);
	strobe_sample(name, -131072);
	for (int i = 0; i < `FILTER_TAPS + 1; i++)
		strobe_sample(name, 0);
endtask

task automatic reset_mid_stream();
	string name;
	name = "reset_mid_stream";
	for (int i = 0; i < 30; i++)
	begin
		strobe_sample(name, random_symbol());
		random_gap(name);
	end
	reset = 1'b1;
	sam_clk_en = 1'b0;
	#1;
	// Asynchronous clear needs no edge
	check_value(name, 0, int'(y));
	hold_reset(name, 2);
	for (int i = 0; i < 40; i++)
	begin
		strobe_sample(name, random_symbol());
		random_gap(name);
	end
endtask

/* verification/pract_filter_tb.sv */
`timescale 1ns/1ps
`include "pract_filter_settings.svh"

module pract_filter_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 5;
	// Polls of 1 ns before a missing clock edge counts as a hang
	localparam int EDGE_TIMEOUT = 4 * CLK_PERIOD;

	logic                      clk;
	logic                      reset;
	logic                      sam_clk_en;
	pract_filter_pkg::sample_t x_in;
	pract_filter_pkg::sample_t y;

	int      error_count;
	int      check_count;
	int      edge_count;
	realtime last_edge_time;

	// Reference copy of the delay line with the newest sample first
	int model_line [0:`FILTER_TAPS-1];
	int expected_y;

	pract_filter pract_filter_i (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.x_in(x_in),
		.y(y)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		edge_count++;
		last_edge_time = $realtime;
	end

	// coeff * q / 4 rounded to nearest with ties away from zero
	function automatic int quarter_product(input int coeff, input int q);
		int num;
		int mag;
		int result;
		num = coeff * q;
		mag = (num < 0) ? -num : num;
		result = mag / 4;
		if (mag % 4 >= 2)
			result = result + 1;
		return (num < 0) ? -result : result;
	endfunction

	function automatic int tap_product(input int coeff, input int folded);
		int q;
		if (folded % `LEVEL_STEP != 0)
			return 0;
		q = folded / `LEVEL_STEP;
		if (q < -6 || q > 6)
			return 0;
		return quarter_product(coeff, q);
	endfunction

	function automatic int model_sum();
		int sum;
		int folded;
		logic signed [`SAMPLE_W-1:0] wrapped;
		sum = 0;
		for (int k = 0; k <= `HALF_TAPS; k++)
		begin
			if (k == `HALF_TAPS)
				folded = model_line[k];
			else
				folded = model_line[k] + model_line[`FILTER_TAPS - 1 - k];
			sum += tap_product(pract_filter_pkg::coeff_table[k], folded);
		end
		// Output keeps only 18 bits
		wrapped = sum[`SAMPLE_W-1:0];
		return int'(wrapped);
	endfunction

	function automatic void model_shift(input int x);
		pract_filter_pkg::sample_t s;
		s = pract_filter_pkg::sample_t'(x);
		for (int i = `FILTER_TAPS - 1; i > 0; i--)
			model_line[i] = model_line[i - 1];
		model_line[0] = int'(s);
	endfunction

	function automatic void model_clear();
		for (int i = 0; i < `FILTER_TAPS; i++)
			model_line[i] = 0;
		expected_y = 0;
	endfunction

	task automatic check_value(input string test_name, input int expected, input int actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
		end
	endtask

	// Returns 1 ns after the next rising edge
	task automatic next_edge();
		int start;
		int polls;
		start = edge_count;
		polls = 0;
		while (edge_count == start && polls < EDGE_TIMEOUT)
		begin
			#1;
			polls++;
		end
		if (edge_count == start)
		begin
			error_count++;
			$display("Timed out: the clock stopped producing rising edges");
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("Some tests failed");
			$finish;
		end
		else if ($realtime < last_edge_time + DRIVE_DELAY)
		begin
			#(last_edge_time + DRIVE_DELAY - $realtime);
		end
	endtask

	task automatic strobe_sample(input string test_name, input int x);
		sam_clk_en = 1'b1;
		x_in = pract_filter_pkg::sample_t'(x);
		expected_y = model_sum();
		model_shift(x);
		next_edge();
		sam_clk_en = 1'b0;
		check_value(test_name, expected_y, int'(y));
	endtask

	// Strobe stays low while x_in wanders and y holds
	task automatic idle_cycles(input string test_name, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			sam_clk_en = 1'b0;
			x_in = pract_filter_pkg::sample_t'($urandom);
			next_edge();
			check_value(test_name, expected_y, int'(y));
		end
	endtask

	task automatic random_gap(input string test_name);
		idle_cycles(test_name, int'($urandom_range(0, 3)));
	endtask

	task automatic hold_reset(input string test_name, input int cycles);
		reset = 1'b1;
		sam_clk_en = 1'b0;
		x_in = '0;
		model_clear();
		for (int i = 0; i < cycles; i++)
		begin
			next_edge();
			check_value(test_name, 0, int'(y));
		end
		reset = 1'b0;
	endtask

	`include "pract_filter_tests.svh"

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		sam_clk_en = 1'b0;
		x_in = '0;
		error_count = 0;
		check_count = 0;
		edge_count = 0;
		last_edge_time = 0;
		void'($urandom(9822));

		hold_reset("power_on_reset", RESET_CYCLES);

		idle_after_reset();
		impulse_response();
		hold_without_strobe();
		pam_stream();
		off_grid_samples();
		reset_mid_stream();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+hw
+incdir+verification
hw/pract_filter_pkg.sv
hw/fir_sample_delay_line.sv
hw/fir_tap_multiplier.sv
hw/fir_adder_tree.sv
hw/pract_filter.sv
verification/pract_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the FIR testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Some tests failed"

rm -rf obj_dir "$LOG" build.log

verilator --binary --timing -Wno-fatal --top-module pract_filter_tb \
	-f all.f -o pract_filter_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/pract_filter_sim > "$LOG" 2>&1 \
	|| { cat "$LOG"; echo "Simulation exited with an error"; exit 1; }

cat "$LOG"

grep -q "$FAIL_TEXT" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "All tests passed" "$LOG" && { echo "PASS"; exit 0; }
echo "FAIL: no result line in $LOG"
exit 1
